// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP = gf_arith_tb
FILELIST = filelist.f
SIM_ARGS = +verilator+error+limit+1000
LOG = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hw/gf_pkg.sv
hw/serial_mixed_multiplier.sv
hw/basis_convert.sv
hw/field_power.sv
hw/mul_sequencer.sv
hw/gf_arith_top.sv
verif/gf_arith_asserts.sv
verif/gf_arith_tb.sv

// ==== hw/basis_convert.sv ====
module basis_convert import gf_pkg::*; #(
	parameter int M = 4,
	parameter bit TO_DUAL = 1'b1
) (
	input logic [M-1:0] in_elem,
	output logic [M-1:0] out_elem
);

	// matrix is fixed at elaboration, so each bit is a small XOR tree
	localparam gf_matrix_t rows = TO_DUAL ? gf_std_to_dual(M) : gf_dual_to_std(M);

	for (genvar i = 0; i < M; i++) begin : g_row
		assign out_elem[i] = ^(in_elem & rows[i][M-1:0]);
	end

endmodule

// ==== hw/field_power.sv ====
module field_power import gf_pkg::*; #(
	parameter int M = 4
) (
	input logic clk,
	input logic reset,
	input logic strobe,
	input gf_cmd_t cmd,
	output logic pow_done,
	output gf_result_t pow_result
);

	localparam gf_matrix_t sq_rows = gf_sq_rows(M);

	logic accept;
	logic [M-1:0] x;
	logic [M-1:0] sq;
	gf_elem_t cube;

	assign accept = strobe && cmd.op == op_pow;
	assign x = cmd.x[M-1:0];

	// x^2 through the constant squaring map
	for (genvar i = 0; i < M; i++) begin : g_sq
		assign sq[i] = ^(x & sq_rows[i][M-1:0]);
	end

	// x^3 = x^2 * x
	assign cube = gf_mul_std(M, gf_elem_t'(sq), gf_elem_t'(x));

	always_ff @(posedge clk) begin
		if (reset) begin
			pow_done <= 1'b0;
			pow_result <= '0;
		end else begin
			pow_done <= accept;
			if (accept) begin
				pow_result.r0 <= gf_elem_t'(sq);
				pow_result.r1 <= cube;
				pow_result.op <= op_pow;
			end
		end
	end

endmodule

// ==== hw/gf_arith_top.sv ====
module gf_arith_top import gf_pkg::*; #(
	parameter int M = 4
) (
	input logic clk,
	input logic reset,
	input logic cmd_strobe,
	input gf_cmd_t cmd,
	output logic busy,
	output logic done,
	output gf_result_t result
);

	logic pow_strobe;
	logic mul_done;
	logic pow_done;
	logic sel_pow;
	logic use_pow;
	gf_result_t mul_result;
	gf_result_t pow_result;

	// only the trinomials in the package table are supported
	if (gf_poly(M) == '0) begin : g_bad_field
		$error("gf_arith_top: no trinomial for M = %0d", M);
	end

	// power commands are dropped while a multiply is running
	assign pow_strobe = cmd_strobe && !busy;

	mul_sequencer #(
		.M(M)
	) u_mul (
		.clk(clk),
		.reset(reset),
		.strobe(cmd_strobe),
		.cmd(cmd),
		.busy(busy),
		.mul_done(mul_done),
		.mul_result(mul_result)
	);

	field_power #(
		.M(M)
	) u_pow (
		.clk(clk),
		.reset(reset),
		.strobe(pow_strobe),
		.cmd(cmd),
		.pow_done(pow_done),
		.pow_result(pow_result)
	);

	// remembers which unit finished last so result holds between dones
	always_ff @(posedge clk) begin
		if (reset)
			sel_pow <= 1'b0;
		else if (pow_done)
			sel_pow <= 1'b1;
		else if (mul_done)
			sel_pow <= 1'b0;
	end

	assign use_pow = pow_done || (sel_pow && !mul_done);
	assign result = use_pow ? pow_result : mul_result;
	assign done = mul_done || pow_done;

endmodule

// ==== hw/gf_pkg.sv ====
package gf_pkg;

	// widest field the structs can carry; modules use only the low M bits
	localparam int gf_max_m = 8;

	typedef logic [gf_max_m-1:0] gf_elem_t;

	// row i of a matrix is the mask that produces output bit i
	typedef logic [gf_max_m-1:0][gf_max_m-1:0] gf_matrix_t;

	typedef enum logic {
		op_mul = 1'b0,
		op_pow = 1'b1
	} gf_op_t;

	typedef struct packed {
		gf_op_t op;
		gf_elem_t x;
		gf_elem_t y0;
		gf_elem_t y1;
	} gf_cmd_t;

	typedef struct packed {
		gf_elem_t r0;
		gf_elem_t r1;
		gf_op_t op;
	} gf_result_t;

	// trinomial field polynomials without the x^m term and zero for an unsupported m
	function automatic gf_elem_t gf_poly(input int m);
		case (m)
			4: return gf_elem_t'(8'h03);
			5: return gf_elem_t'(8'h05);
			6: return gf_elem_t'(8'h03);
			7: return gf_elem_t'(8'h03);
			default: return '0;
		endcase
	endfunction

	// shift-and-add product reduced after every shift
	function automatic gf_elem_t gf_mul_std(input int m, input gf_elem_t a, input gf_elem_t b);
		gf_elem_t mask;
		gf_elem_t poly;
		gf_elem_t sh;
		gf_elem_t acc;
		mask = gf_elem_t'((1 << m) - 1);
		poly = gf_poly(m);
		sh = a & mask;
		acc = '0;
		for (int i = 0; i < gf_max_m; i++) begin
			if (i < m && b[i])
				acc ^= sh;
			if (sh[m-1])
				sh = ((sh << 1) ^ poly) & mask;
			else
				sh = (sh << 1) & mask;
		end
		return acc;
	endfunction

	function automatic gf_elem_t gf_alpha_pow(input int m, input int k);
		gf_elem_t e;
		e = gf_elem_t'(1);
		for (int i = 0; i < k; i++)
			e = gf_mul_std(m, e, gf_elem_t'(2));
		return e;
	endfunction

	// sum of the conjugates; the result lies in GF(2)
	function automatic logic gf_trace(input int m, input gf_elem_t e);
		gf_elem_t t;
		gf_elem_t s;
		t = e;
		s = e;
		for (int i = 1; i < m; i++) begin
			t = gf_mul_std(m, t, t);
			s ^= t;
		end
		return s[0];
	endfunction

	// dual coordinate i of z is Tr(z * alpha^i)
	function automatic gf_matrix_t gf_std_to_dual(input int m);
		gf_matrix_t rows;
		rows = '0;
		for (int i = 0; i < m; i++)
			for (int j = 0; j < m; j++)
				rows[i][j] = gf_trace(m, gf_alpha_pow(m, i + j));
		return rows;
	endfunction

	function automatic gf_matrix_t gf_dual_to_std(input int m);
		gf_matrix_t fwd;
		gf_matrix_t inv;
		gf_elem_t el;
		gf_elem_t d;
		fwd = gf_std_to_dual(m);
		inv = '0;
		// the element that maps onto dual unit vector i is column i of the inverse
		for (int e = 1; e < (1 << m); e++) begin
			el = gf_elem_t'(e);
			d = '0;
			for (int i = 0; i < m; i++)
				d[i] = ^(fwd[i] & el);
			for (int i = 0; i < m; i++)
				if (d == (gf_elem_t'(1) << i))
					for (int r = 0; r < m; r++)
						inv[r][i] = el[r];
		end
		return inv;
	endfunction

	// squaring is linear; column j is alpha^(2j)
	function automatic gf_matrix_t gf_sq_rows(input int m);
		gf_matrix_t rows;
		gf_elem_t p;
		rows = '0;
		for (int j = 0; j < m; j++) begin
			p = gf_alpha_pow(m, 2 * j);
			for (int i = 0; i < m; i++)
				rows[i][j] = p[i];
		end
		return rows;
	endfunction

endpackage

// ==== hw/mul_sequencer.sv ====
module mul_sequencer import gf_pkg::*; #(
	parameter int M = 4
) (
	input logic clk,
	input logic reset,
	input logic strobe,
	input gf_cmd_t cmd,
	output logic busy,
	output logic mul_done,
	output gf_result_t mul_result
);

	localparam int cnt_w = $clog2(M + 1);

	logic accept;
	logic last_bit;
	logic [cnt_w-1:0] bit_cnt;
	logic [M-1:0] x_dual;
	logic [M-1:0] y0_std;
	logic [M-1:0] y1_std;
	logic [1:0] prod_bit;
	// first M-1 dual bits of each product; the last bit comes straight from the multiplier
	logic [M-2:0] coll0;
	logic [M-2:0] coll1;
	logic [M-1:0] r0_std;
	logic [M-1:0] r1_std;

	assign accept = strobe && !busy && cmd.op == op_mul;
	assign last_bit = busy && bit_cnt == cnt_w'(M - 1);

	basis_convert #(
		.M(M),
		.TO_DUAL(1'b1)
	) u_x_to_dual (
		.in_elem(cmd.x[M-1:0]),
		.out_elem(x_dual)
	);

	// one multiplier shares the dual x with both standard operands
	serial_mixed_multiplier #(
		.M(M),
		.N_INPUT(2)
	) u_mult (
		.clk(clk),
		.reset(reset),
		.start(accept),
		.dual_in(x_dual),
		.standard_in({y1_std, y0_std}),
		.dual_out(prod_bit)
	);

	basis_convert #(
		.M(M),
		.TO_DUAL(1'b0)
	) u_r0_to_std (
		.in_elem({prod_bit[0], coll0}),
		.out_elem(r0_std)
	);

	basis_convert #(
		.M(M),
		.TO_DUAL(1'b0)
	) u_r1_to_std (
		.in_elem({prod_bit[1], coll1}),
		.out_elem(r1_std)
	);

	always_ff @(posedge clk) begin
		if (accept) begin
			y0_std <= cmd.y0[M-1:0];
			y1_std <= cmd.y1[M-1:0];
		end
		// low coordinates enter first and end up at bit 0
		if (busy) begin
			coll0 <= {prod_bit[0], coll0[M-2:1]};
			coll1 <= {prod_bit[1], coll1[M-2:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			mul_done <= 1'b0;
		end else begin
			mul_done <= last_bit;
			if (accept) begin
				busy <= 1'b1;
				bit_cnt <= '0;
			end else if (mul_done) begin
				// busy drops together with the done pulse
				busy <= 1'b0;
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mul_result <= '0;
		end else if (last_bit) begin
			mul_result.r0 <= gf_elem_t'(r0_std);
			mul_result.r1 <= gf_elem_t'(r1_std);
			mul_result.op <= op_mul;
		end
	end

endmodule

// ==== hw/serial_mixed_multiplier.sv ====
module serial_mixed_multiplier import gf_pkg::*; #(
	parameter int M = 4,
	parameter int N_INPUT = 1
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [M-1:0] dual_in,
	input logic [M*N_INPUT-1:0] standard_in,
	output logic [N_INPUT-1:0] dual_out
);

	localparam gf_elem_t poly = gf_poly(M);

	// holds dual coordinates k .. k+M-1 of the dual operand
	logic [M-1:0] lfsr;

	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= '0;
		end else if (start) begin
			lfsr <= dual_in;
		end else begin
			// next coordinate follows from the field recurrence
			lfsr <= {^(lfsr & poly[M-1:0]), lfsr[M-1:1]};
		end
	end

	// coordinate k of each product appears k cycles after the load
	for (genvar i = 0; i < N_INPUT; i++) begin : g_out
		assign dual_out[i] = ^(standard_in[M*i +: M] & lfsr);
	end

endmodule

// ==== verif/gf_arith_asserts.sv ====
module gf_arith_asserts import gf_pkg::*; #(
	parameter int M = 4
) (
	input logic clk,
	input logic reset,
	input logic cmd_strobe,
	input gf_cmd_t cmd,
	input logic busy,
	input logic done,
	input gf_result_t result
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam gf_elem_t elem_mask = gf_elem_t'((1 << M) - 1);
	// full field polynomial including the x^M term
	localparam logic [2*gf_max_m-1:0] full_poly =
		{{gf_max_m{1'b0}}, gf_poly(M)} | ((2 * gf_max_m)'(1) << M);

	int fail_count = 0;

	// model of the last accepted command
	logic [3:0] wait_cnt;
	gf_op_t exp_op;
	gf_elem_t exp_r0;
	gf_elem_t exp_r1;
	logic model_busy;
	logic accept;

	// carry-less product followed by long division by the field polynomial
	function automatic gf_elem_t ref_mul(input gf_elem_t a, input gf_elem_t b);
		logic [2*gf_max_m-1:0] prod;
		prod = '0;
		for (int i = 0; i < M; i++)
			if (b[i])
				prod ^= {{gf_max_m{1'b0}}, a & elem_mask} << i;
		for (int i = 2 * M - 2; i >= M; i--)
			if (prod[i])
				prod ^= full_poly << (i - M);
		return prod[gf_max_m-1:0];
	endfunction

	assign model_busy = wait_cnt != 0 && exp_op == op_mul;
	assign accept = cmd_strobe && !model_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= '0;
			exp_op <= op_mul;
			exp_r0 <= '0;
			exp_r1 <= '0;
		end else if (accept) begin
			exp_op <= cmd.op;
			if (cmd.op == op_mul) begin
				// done is sampled M+1 edges after acceptance
				wait_cnt <= 4'(M + 1);
				exp_r0 <= ref_mul(cmd.x, cmd.y0);
				exp_r1 <= ref_mul(cmd.x, cmd.y1);
			end else begin
				wait_cnt <= 4'd1;
				exp_r0 <= ref_mul(cmd.x, cmd.x);
				exp_r1 <= ref_mul(ref_mul(cmd.x, cmd.x), cmd.x);
			end
		end else if (wait_cnt != 0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end
	end

	a_reset: assert property (@(posedge clk) $past(reset) |-> !busy && !done && result == '0)
		else begin
			fail_count++;
			$error("busy, done or result not cleared by reset");
		end

	a_busy: assert property (@(posedge clk) disable iff (reset) busy == model_busy)
		else begin
			fail_count++;
			$error("Fail busy got %h expected %h", busy, model_busy);
		end

	a_done: assert property (@(posedge clk) disable iff (reset) done == (wait_cnt == 1))
		else begin
			fail_count++;
			$error("Fail done got %h expected %h", done, wait_cnt == 1);
		end

	a_r0: assert property (@(posedge clk) disable iff (reset) done |-> result.r0 == exp_r0)
		else begin
			fail_count++;
			$error("Fail r0 got %h expected %h", result.r0, exp_r0);
		end

	a_r1: assert property (@(posedge clk) disable iff (reset) done |-> result.r1 == exp_r1)
		else begin
			fail_count++;
			$error("Fail r1 got %h expected %h", result.r1, exp_r1);
		end

	a_op: assert property (@(posedge clk) disable iff (reset) done |-> result.op == exp_op)
		else begin
			fail_count++;
			$error("Fail op got %h expected %h", result.op, exp_op);
		end

	// result only moves together with done
	a_hold: assert property (@(posedge clk) disable iff (reset) !done |-> $stable(result))
		else begin
			fail_count++;
			$error("result changed while done was low");
		end

endmodule

bind gf_arith_top gf_arith_asserts #(
	.M(M)
) u_asserts (
	.clk(clk),
	.reset(reset),
	.cmd_strobe(cmd_strobe),
	.cmd(cmd),
	.busy(busy),
	.done(done),
	.result(result)
);

// ==== verif/gf_arith_tb.sv ====
module gf_arith_tb import gf_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int M = 4;
	localparam int clk_period = 4;
	localparam int reset_cycles = 8;
	localparam int n_random = 200;
	localparam int done_limit = M + 3;
	// each command needs at most M+3 cycles and the directed ones fit in the spare budget
	localparam int run_limit = 220 * (M + 3) * clk_period + reset_cycles * clk_period;
	localparam gf_elem_t elem_mask = gf_elem_t'((1 << M) - 1);

	logic clk;
	logic reset;
	logic cmd_strobe;
	gf_cmd_t cmd;
	logic busy;
	logic done;
	gf_result_t result;

	int seed = 32'h47fb;
	int missed_done = 0;

	gf_arith_top #(
		.M(M)
	) uut (
		.clk(clk),
		.reset(reset),
		.cmd_strobe(cmd_strobe),
		.cmd(cmd),
		.busy(busy),
		.done(done),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(run_limit);
		$display("watchdog expired after %0d ns, a command never finished", run_limit);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic gf_cmd_t make_cmd(input gf_op_t op, input int x, input int y0,
		input int y1);
		gf_cmd_t c;
		c.op = op;
		c.x = gf_elem_t'(x) & elem_mask;
		c.y0 = gf_elem_t'(y0) & elem_mask;
		c.y1 = gf_elem_t'(y1) & elem_mask;
		return c;
	endfunction

	function automatic gf_cmd_t random_cmd();
		return make_cmd(gf_op_t'($random(seed) & 1), $random(seed), $random(seed), $random(seed));
	endfunction

	// strobe one command and wait for its done while optionally poking extra strobes
	task automatic run_cmd(input gf_cmd_t c, input bit poke);
		int waited;
		@(negedge clk);
		cmd_strobe = 1'b1;
		cmd = c;
		@(negedge clk);
		cmd_strobe = 1'b0;
		waited = 0;
		while (!done && waited < done_limit) begin
			cmd_strobe = poke && busy && (waited == 1 || waited == M - 1);
			if (cmd_strobe)
				cmd = random_cmd();
			@(negedge clk);
			waited++;
		end
		cmd_strobe = 1'b0;
		if (!done) begin
			missed_done++;
			$display("no done within %0d cycles after a command", done_limit);
		end
	endtask

	initial begin
		reset = 1'b1;
		cmd_strobe = 1'b0;
		cmd = '0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// identity, zero operands and the inverse of alpha
		run_cmd(make_cmd(op_mul, 1, 5, 'ha), 1'b0);
		run_cmd(make_cmd(op_mul, 0, 7, 3), 1'b0);
		run_cmd(make_cmd(op_mul, 6, 0, 9), 1'b0);
		run_cmd(make_cmd(op_mul, int'(gf_alpha_pow(M, (1 << M) - 2)), 2, 'hf), 1'b1);
		run_cmd(make_cmd(op_pow, 0, 0, 0), 1'b0);
		run_cmd(make_cmd(op_pow, 1, 0, 0), 1'b0);
		run_cmd(make_cmd(op_pow, 2, 0, 0), 1'b0);
		run_cmd(make_cmd(op_pow, int'(elem_mask), 0, 0), 1'b0);
		run_cmd(make_cmd(op_mul, int'(elem_mask), int'(elem_mask), 1), 1'b1);

		for (int i = 0; i < n_random; i++)
			run_cmd(random_cmd(), i % 4 == 0);

		repeat (2) @(negedge clk);
		$display("assertion failures: %0d, commands without done: %0d",
			uut.u_asserts.fail_count, missed_done);
		if (uut.u_asserts.fail_count == 0 && missed_done == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
